// ==== move_gen_defines.svh ====
`ifndef MOVE_GEN_DEFINES_SVH
`define MOVE_GEN_DEFINES_SVH

// AXI4-Lite bus widths
`define MG_ADDR_W 12
`define MG_DATA_W 32

// board squares sit at 4*n below this address, control registers from here up
`define MG_CTRL_BASE 12'h100

// squares on the board, one cell each
`define MG_BOARD_SQUARES 64

// cycles spent moving sliders along their rays, longest ray is 7 squares
`define MG_PROP_CYCLES 8

`endif

// ==== chess_pkg.sv ====
package chess_pkg;

	typedef enum logic [2:0] {
		P_EMPTY, P_PAWN, P_KNIGHT, P_BISHOP, P_ROOK, P_QUEEN, P_KING, P_UNUSED
	} piece_e;

	typedef enum logic {
		C_WHITE = 1'b0,
		C_BLACK = 1'b1
	} colour_e;

	// piece code as written by the host
	typedef struct packed {
		colour_e colour;
		piece_e  piece;
	} square_t;

	// what travels between cells, colour is implied white
	typedef struct packed {
		logic [5:0] origin;
		piece_e     piece;
	} link_t;

	// direction of travel of an incoming link, knight jumps in the upper half
	typedef enum logic [3:0] {
		D_UL, D_U, D_UR, D_L, D_R, D_DL, D_D, D_DR,
		D_N_UUL, D_N_UUR, D_N_ULL, D_N_URR, D_N_DLL, D_N_DRR, D_N_DDL, D_N_DDR
	} dir_e;

	typedef struct packed {
		logic invalid;
		logic promote;
		logic pawn;
		logic pawn_double;
		logic en_passant;
		logic castle;
		logic capture;
	} move_flags_t;

	// square index is column*8 + row
	typedef struct packed {
		move_flags_t flags;
		logic [5:0]  from_sq;
		logic [5:0]  to_sq;
	} move_t;

	typedef enum logic [2:0] {
		RUN_IDLE, RUN_LOAD, RUN_GENERATE, RUN_PROPAGATE, RUN_KNIGHT, RUN_SCAN, RUN_DONE
	} run_state_e;

endpackage

// ==== bus_pkg.sv ====
package bus_pkg;

`include "move_gen_defines.svh"

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

	typedef enum logic [2:0] {
		REG_BOARD, REG_CTRL, REG_STATUS, REG_MOVE, REG_NONE
	} reg_sel_e;

	// word aligned decode, the board fills everything below the control base
	function automatic reg_sel_e reg_decode(input logic [`MG_ADDR_W-1:0] addr);
		reg_sel_e sel;
		if (addr[1:0] != 2'b00)
			sel = REG_NONE;
		else if (addr < `MG_CTRL_BASE)
			sel = REG_BOARD;
		else if (addr == `MG_CTRL_BASE)
			sel = REG_CTRL;
		else if (addr == `MG_CTRL_BASE + 12'h004)
			sel = REG_STATUS;
		else if (addr == `MG_CTRL_BASE + 12'h008)
			sel = REG_MOVE;
		else
			sel = REG_NONE;
		return sel;
	endfunction

endpackage

// ==== move_if.sv ====
`timescale 1ns/1ns

interface move_if;
	import chess_pkg::*;

	logic  move_valid;
	move_t move;
	logic  move_ready;
	// run status seen by the status register
	logic  busy;
	logic  done;

	modport grid (
		output move_valid, move, busy, done,
		input  move_ready
	);

	modport collector (
		input  move_valid, move, busy, done,
		output move_ready
	);

endinterface

// ==== board_loader.sv ====
`timescale 1ns/1ns
`include "move_gen_defines.svh"

module board_loader (
	input  logic                                       clk,
	input  logic                                       arst_n,
	input  logic [`MG_ADDR_W-1:0]                      awaddr,
	input  logic                                       awvalid,
	output logic                                       awready,
	input  logic [`MG_DATA_W-1:0]                      wdata,
	input  logic                                       wvalid,
	output logic                                       wready,
	output bus_pkg::axi_resp_e                         bresp,
	output logic                                       bvalid,
	input  logic                                       bready,
	output chess_pkg::square_t [`MG_BOARD_SQUARES-1:0] board,
	output logic                                       start
);
	import bus_pkg::*;

	localparam int SQ_W = $clog2(`MG_BOARD_SQUARES);

	logic     wr_rdy;
	logic     wr_hs;
	reg_sel_e wr_sel;

	// address and data are taken together
	assign awready = wr_rdy;
	assign wready = wr_rdy;
	assign wr_hs = awvalid && wvalid && wr_rdy;
	assign wr_sel = reg_decode(awaddr);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_rdy <= 1'b0;
			bvalid <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= wr_hs && (wr_sel == REG_CTRL) && wdata[0];
			if (wr_hs) begin
				wr_rdy <= 1'b0;
				bvalid <= 1'b1;
			end else if (bvalid && bready) begin
				wr_rdy <= 1'b1;
				bvalid <= 1'b0;
			end else if (!bvalid) begin
				wr_rdy <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_hs) begin
			// only board and ctrl are writable
			if (wr_sel == REG_BOARD || wr_sel == REG_CTRL)
				bresp <= RESP_OKAY;
			else
				bresp <= RESP_SLVERR;
		end
	end

	// the grid snapshots this at start, so late writes wait for the next run
	always_ff @(posedge clk) begin
		if (wr_hs && wr_sel == REG_BOARD)
			board[awaddr[SQ_W+1:2]] <= wdata[3:0];
	end

endmodule

// ==== square_cell.sv ====
`timescale 1ns/1ns

module square_cell (
	input  logic                     clk,
	input  logic                     arst_n,
	input  chess_pkg::run_state_e    cell_state,
	input  chess_pkg::square_t       square,
	input  logic [5:0]               self_pos,
	input  chess_pkg::link_t [15:0]  link_in,
	output chess_pkg::link_t [15:0]  link_out,
	output logic [15:0]              move_mask,
	output chess_pkg::link_t [15:0]  move_src,
	input  logic                     take
);
	import chess_pkg::*;

	logic             self_empty;
	logic             self_black;
	link_t            own_link;
	link_t [15:0]     link_nxt;
	logic [15:0]      land;

	// does piece p slide along king direction d
	function automatic logic slides(piece_e p, int d);
		logic diag;
		logic orth;
		diag = (d == D_UL || d == D_UR || d == D_DL || d == D_DR);
		orth = (d == D_U || d == D_L || d == D_R || d == D_D);
		return (diag && (p == P_BISHOP || p == P_QUEEN)) ||
			(orth && (p == P_ROOK || p == P_QUEEN));
	endfunction

	// outgoing links a piece starts on
	function automatic logic emits(piece_e p, int d);
		logic hit;
		if (d >= 8)
			hit = (p == P_KNIGHT);
		else
			hit = slides(p, d) || (p == P_KING) ||
				(p == P_PAWN && (d == D_UL || d == D_U || d == D_UR));
		return hit;
	endfunction

	assign self_empty = (square.piece == P_EMPTY);
	assign self_black = (square.colour == C_BLACK) && !self_empty;
	assign own_link = '{origin: self_pos, piece: square.piece};

	always_comb begin
		link_nxt = '0;
		land = '0;
		case (cell_state)
			RUN_GENERATE: begin
				if (square.colour == C_WHITE) begin
					for (int d = 0; d < 16; d++) begin
						if (emits(square.piece, d))
							link_nxt[d] = own_link;
					end
				end
			end
			RUN_PROPAGATE: begin
				for (int d = 0; d < 8; d++) begin
					if (link_in[d].piece == P_PAWN) begin
						// pawns push onto empty, capture only diagonally
						land[d] = (d == D_U) ? self_empty :
							((d == D_UL || d == D_UR) && self_black);
					end else if (link_in[d].piece != P_EMPTY) begin
						land[d] = self_empty || self_black;
					end
					// rays pass through empty squares only
					if (self_empty && slides(link_in[d].piece, d))
						link_nxt[d] = link_in[d];
				end
				// second step of a double push, from row 1 through empty row 2
				if (self_empty && self_pos[2:0] == 3'd2 && link_in[D_U].piece == P_PAWN &&
					link_in[D_U].origin[2:0] == 3'd1)
					link_nxt[D_U] = link_in[D_U];
				// knight jumps stay up until the knight cycle
				link_nxt[15:8] = link_out[15:8];
			end
			RUN_KNIGHT: begin
				for (int d = 8; d < 16; d++) begin
					land[d] = (link_in[d].piece != P_EMPTY) && (self_empty || self_black);
				end
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			link_out <= '0;
			move_mask <= '0;
		end else begin
			link_out <= link_nxt;
			if (cell_state == RUN_LOAD)
				move_mask <= '0;
			else if (take)
				// drop the move just handed out, lowest bit first
				move_mask <= move_mask & (move_mask - 16'd1);
			else
				move_mask <= move_mask | land;
		end
	end

	always_ff @(posedge clk) begin
		for (int d = 0; d < 16; d++) begin
			if (land[d])
				move_src[d] <= link_in[d];
		end
	end

endmodule

// ==== move_grid.sv ====
`timescale 1ns/1ns
`include "move_gen_defines.svh"

module move_grid (
	input  logic                                       clk,
	input  logic                                       arst_n,
	input  chess_pkg::square_t [`MG_BOARD_SQUARES-1:0] board,
	input  logic                                       start,
	move_if.grid                                       mv
);
	import chess_pkg::*;

	localparam int NSQ = `MG_BOARD_SQUARES;

	run_state_e              state;
	logic [3:0]              prop_cnt;
	logic [5:0]              scan_idx;
	square_t [NSQ-1:0]       board_q;
	wire link_t [15:0]       cell_out [NSQ];
	wire link_t [15:0]       cell_in [NSQ];
	wire link_t [15:0]       cell_src [NSQ];
	wire logic [15:0]        cell_mask [NSQ];
	logic [NSQ-1:0]          take;
	logic [15:0]             cur_mask;
	logic [3:0]              cur_bit;
	link_t                   src;
	square_t                 dst;

	// column step of a direction of travel
	function automatic int dir_dcol(int d);
		case (d)
			D_UL, D_L, D_DL, D_N_UUL, D_N_DDL: return -1;
			D_UR, D_R, D_DR, D_N_UUR, D_N_DDR: return 1;
			D_N_ULL, D_N_DLL: return -2;
			D_N_URR, D_N_DRR: return 2;
			default: return 0;
		endcase
	endfunction

	// row step of a direction of travel, up is towards row 7
	function automatic int dir_drow(int d);
		case (d)
			D_UL, D_U, D_UR, D_N_ULL, D_N_URR: return 1;
			D_DL, D_D, D_DR, D_N_DLL, D_N_DRR: return -1;
			D_N_UUL, D_N_UUR: return 2;
			D_N_DDL, D_N_DDR: return -2;
			default: return 0;
		endcase
	endfunction

	function automatic logic [3:0] lowest_bit(logic [15:0] m);
		logic [3:0] idx;
		idx = '0;
		for (int i = 15; i >= 0; i--) begin
			if (m[i])
				idx = 4'(i);
		end
		return idx;
	endfunction

	for (genvar n = 0; n < NSQ; n++) begin : g_cell
		for (genvar d = 0; d < 16; d++) begin : g_link
			// a link arriving on direction d left the square one step behind
			localparam int SC = n / 8 - dir_dcol(d);
			localparam int SR = n % 8 - dir_drow(d);
			if (SC >= 0 && SC < 8 && SR >= 0 && SR < 8) begin : g_wire
				assign cell_in[n][d] = cell_out[SC * 8 + SR][d];
			end else begin : g_edge
				assign cell_in[n][d] = '0;
			end
		end

		square_cell u_cell (
			.clk        (clk),
			.arst_n     (arst_n),
			.cell_state (state),
			.square     (board_q[n]),
			.self_pos   (6'(n)),
			.link_in    (cell_in[n]),
			.link_out   (cell_out[n]),
			.move_mask  (cell_mask[n]),
			.move_src   (cell_src[n]),
			.take       (take[n])
		);
	end

	always_ff @(posedge clk) begin
		if (start)
			board_q <= board;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= RUN_IDLE;
			prop_cnt <= '0;
			scan_idx <= '0;
		end else if (start) begin
			// a new start abandons whatever is left of the last run
			state <= RUN_LOAD;
		end else begin
			case (state)
				RUN_LOAD: state <= RUN_GENERATE;
				RUN_GENERATE: begin
					state <= RUN_PROPAGATE;
					prop_cnt <= '0;
				end
				RUN_PROPAGATE: begin
					if (prop_cnt == 4'(`MG_PROP_CYCLES - 1))
						state <= RUN_KNIGHT;
					else
						prop_cnt <= prop_cnt + 4'd1;
				end
				RUN_KNIGHT: begin
					state <= RUN_SCAN;
					scan_idx <= '0;
				end
				RUN_SCAN: begin
					// stay on a cell until its moves are drained
					if (cur_mask == '0) begin
						if (scan_idx == 6'(NSQ - 1))
							state <= RUN_DONE;
						else
							scan_idx <= scan_idx + 6'd1;
					end
				end
				default: begin
				end
			endcase
		end
	end

	assign cur_mask = cell_mask[scan_idx];
	assign cur_bit = lowest_bit(cur_mask);
	assign src = cell_src[scan_idx][cur_bit];
	assign dst = board_q[scan_idx];

	assign mv.move_valid = (state == RUN_SCAN) && (cur_mask != '0);
	assign mv.busy = (state != RUN_IDLE) && (state != RUN_DONE);
	assign mv.done = (state == RUN_DONE);
	assign take = (mv.move_valid && mv.move_ready) ? (NSQ'(1) << scan_idx) : '0;

	always_comb begin
		mv.move.flags.invalid = 1'b0;
		mv.move.flags.promote = (src.piece == P_PAWN) && (scan_idx[2:0] == 3'd7);
		mv.move.flags.pawn = (src.piece == P_PAWN);
		mv.move.flags.pawn_double = (src.piece == P_PAWN) &&
			(scan_idx[2:0] - src.origin[2:0] == 3'd2);
		mv.move.flags.en_passant = 1'b0;
		mv.move.flags.castle = 1'b0;
		mv.move.flags.capture = (dst.colour == C_BLACK) && (dst.piece != P_EMPTY);
		mv.move.from_sq = src.origin;
		mv.move.to_sq = scan_idx;
	end

endmodule

// ==== move_collector.sv ====
`timescale 1ns/1ns
`include "move_gen_defines.svh"

module move_collector (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`MG_ADDR_W-1:0] araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [`MG_DATA_W-1:0] rdata,
	output bus_pkg::axi_resp_e    rresp,
	output logic                  rvalid,
	input  logic                  rready,
	move_if.collector             mv
);
	import bus_pkg::*;
	import chess_pkg::*;

	localparam int DW = `MG_DATA_W;
	// returned when the grid has nothing to offer
	localparam move_t MOVE_NONE = '{flags: 7'b100_0000, from_sq: 6'd0, to_sq: 6'd0};

	logic     rd_hs;
	reg_sel_e rd_sel;

	assign rd_hs = arvalid && arready;
	assign rd_sel = reg_decode(araddr);
	// pops the grid in the same cycle the read is accepted
	assign mv.move_ready = rd_hs && (rd_sel == REG_MOVE);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else if (rd_hs) begin
			arready <= 1'b0;
			rvalid <= 1'b1;
		end else if (rvalid && rready) begin
			arready <= 1'b1;
			rvalid <= 1'b0;
		end else if (!rvalid) begin
			arready <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_hs) begin
			case (rd_sel)
				REG_STATUS: begin
					rdata <= DW'({mv.done, mv.busy});
					rresp <= RESP_OKAY;
				end
				REG_MOVE: begin
					rdata <= mv.move_valid ? DW'(mv.move) : DW'(MOVE_NONE);
					rresp <= RESP_OKAY;
				end
				default: begin
					rdata <= '0;
					rresp <= RESP_SLVERR;
				end
			endcase
		end
	end

endmodule

// ==== move_gen_top.sv ====
`timescale 1ns/1ns
`include "move_gen_defines.svh"

module move_gen_top (
	input  logic                  clk,
	input  logic                  arst_n,
	// write channels
	input  logic [`MG_ADDR_W-1:0] awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [`MG_DATA_W-1:0] wdata,
	input  logic                  wvalid,
	output logic                  wready,
	output bus_pkg::axi_resp_e    bresp,
	output logic                  bvalid,
	input  logic                  bready,
	// read channels
	input  logic [`MG_ADDR_W-1:0] araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [`MG_DATA_W-1:0] rdata,
	output bus_pkg::axi_resp_e    rresp,
	output logic                  rvalid,
	input  logic                  rready
);
	import chess_pkg::*;

	square_t [`MG_BOARD_SQUARES-1:0] board;
	logic                            start;

	move_if mv ();

	board_loader u_loader (
		.clk     (clk),
		.arst_n  (arst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.board   (board),
		.start   (start)
	);

	move_grid u_grid (
		.clk    (clk),
		.arst_n (arst_n),
		.board  (board),
		.start  (start),
		.mv     (mv)
	);

	move_collector u_collector (
		.clk     (clk),
		.arst_n  (arst_n),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.mv      (mv)
	);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk,
	output logic arst_n
);
	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		// hold reset for 8 rising edges, release on an edge
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
	end

	always #2 clk = ~clk;

endmodule

// ==== tb_move_gen.sv ====
`timescale 1ns/1ns
`include "move_gen_defines.svh"

module tb_move_gen;
	import chess_pkg::*;
	import bus_pkg::*;

	localparam int MAX_POS = 8;
	localparam int WAIT_LIMIT = 100;
	localparam int READ_LIMIT = 300;
	localparam logic [`MG_ADDR_W-1:0] ADDR_CTRL = `MG_CTRL_BASE;
	localparam logic [`MG_ADDR_W-1:0] ADDR_STATUS = `MG_CTRL_BASE + 12'h004;
	localparam logic [`MG_ADDR_W-1:0] ADDR_MOVE = `MG_CTRL_BASE + 12'h008;

	logic                  clk;
	logic                  arst_n;
	logic [`MG_ADDR_W-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [`MG_DATA_W-1:0] wdata;
	logic                  wvalid;
	logic                  wready;
	axi_resp_e             bresp;
	logic                  bvalid;
	logic                  bready;
	logic [`MG_ADDR_W-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic [`MG_DATA_W-1:0] rdata;
	axi_resp_e             rresp;
	logic                  rvalid;
	logic                  rready;

	int          err_cnt;
	logic [31:0] rng_state;
	logic [3:0]  pos_board [MAX_POS][64];
	move_t       exp_moves [$];
	int          exp_first [MAX_POS];
	int          exp_count [MAX_POS];
	int          num_pos;
	move_t       none_word;

	tb_clock_gen u_clk (
		.clk    (clk),
		.arst_n (arst_n)
	);

	move_gen_top UUT (
		.clk     (clk),
		.arst_n  (arst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic report_mismatch(input string msg);
		err_cnt++;
		$display("MISMATCH at %0t ns: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic report_failure(input string msg);
		err_cnt++;
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_move(input move_t got, input move_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s: move %05h, expected %05h", what, got, exp));
	endtask

	task automatic check_status(input logic busy_got, input logic done_got,
		input logic busy_exp, input logic done_exp, input string what);
		if (busy_got !== busy_exp || done_got !== done_exp)
			report_mismatch($sformatf("%s: busy %b done %b, expected busy %b done %b",
				what, busy_got, done_got, busy_exp, done_exp));
	endtask

	task automatic check_resp(input axi_resp_e got, input axi_resp_e exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s: resp %b, expected %b", what, got, exp));
	endtask

	task automatic check_data(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s: data %08h, expected %08h", what, got, exp));
	endtask

	// next whitespace separated token, lines starting with # are skipped
	task automatic next_token(input int fd, output string tok);
		string rest;
		int    n;
		tok = "";
		n = $fscanf(fd, "%s", tok);
		while (n == 1 && tok.substr(0, 0) == "#") begin
			n = $fgets(rest, fd);
			n = $fscanf(fd, "%s", tok);
		end
		if (n != 1)
			tok = "";
	endtask

	task automatic read_vectors();
		int          fd;
		int          p;
		int          n;
		string       tok;
		logic [31:0] val;
		fd = $fopen("move_vectors.txt", "r");
		if (fd == 0)
			report_failure("cannot open move_vectors.txt");
		num_pos = 0;
		next_token(fd, tok);
		while (tok != "") begin
			if (tok != "pos" || num_pos >= MAX_POS)
				report_failure("vector file is malformed, expected a pos block");
			p = num_pos;
			for (int sq = 0; sq < 64; sq++) begin
				next_token(fd, tok);
				n = $sscanf(tok, "%h", val);
				if (n != 1)
					report_failure("vector file is malformed, bad piece code");
				pos_board[p][sq] = val[3:0];
			end
			exp_first[p] = exp_moves.size();
			exp_count[p] = 0;
			next_token(fd, tok);
			while (tok != "end") begin
				n = $sscanf(tok, "%h", val);
				if (tok == "" || n != 1)
					report_failure("vector file is malformed, bad move word");
				exp_moves.push_back(move_t'(val[18:0]));
				exp_count[p]++;
				next_token(fd, tok);
			end
			num_pos++;
			next_token(fd, tok);
		end
		$fclose(fd);
	endtask

	task automatic bus_write(input logic [`MG_ADDR_W-1:0] addr, input logic [31:0] data,
		output axi_resp_e resp);
		int cnt;
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wvalid <= 1'b1;
		cnt = 0;
		@(negedge clk);
		while (!(awready && wready)) begin
			cnt++;
			if (cnt > WAIT_LIMIT)
				report_failure("timeout waiting for awready and wready");
			@(negedge clk);
		end
		// accepted on this edge
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		cnt = 0;
		@(negedge clk);
		while (!bvalid) begin
			cnt++;
			if (cnt > WAIT_LIMIT)
				report_failure("timeout waiting for bvalid");
			@(negedge clk);
		end
		resp = bresp;
		@(posedge clk);
	endtask

	task automatic bus_read(input logic [`MG_ADDR_W-1:0] addr, input int delay,
		output logic [31:0] data, output axi_resp_e resp);
		int cnt;
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b0;
		cnt = 0;
		@(negedge clk);
		while (!arready) begin
			cnt++;
			if (cnt > WAIT_LIMIT)
				report_failure("timeout waiting for arready");
			@(negedge clk);
		end
		@(posedge clk);
		arvalid <= 1'b0;
		cnt = 0;
		@(negedge clk);
		while (!rvalid) begin
			cnt++;
			if (cnt > WAIT_LIMIT)
				report_failure("timeout waiting for rvalid");
			@(negedge clk);
		end
		data = rdata;
		resp = rresp;
		// back-pressure, the response must stay put and no new read is taken
		repeat (delay) begin
			@(negedge clk);
			if (!rvalid || rdata !== data || arready !== 1'b0)
				report_mismatch("read response not held while rready is low");
		end
		@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic load_board(input int p);
		axi_resp_e resp;
		for (int sq = 0; sq < 64; sq++) begin
			bus_write(`MG_ADDR_W'(4 * sq), {28'd0, pos_board[p][sq]}, resp);
			check_resp(resp, RESP_OKAY, $sformatf("board write square %0d", sq));
		end
	endtask

	task automatic start_run();
		axi_resp_e resp;
		bus_write(ADDR_CTRL, 32'd1, resp);
		check_resp(resp, RESP_OKAY, "start write");
	endtask

	// first move of a run, reads return the invalid word until the scan offers one
	task automatic read_first_move(output move_t got);
		logic [31:0] data;
		axi_resp_e   resp;
		int          cnt;
		cnt = 0;
		bus_read(ADDR_MOVE, 0, data, resp);
		got = data[18:0];
		while (got.flags.invalid) begin
			cnt++;
			if (cnt > WAIT_LIMIT)
				report_failure("no move was offered after start");
			bus_read(ADDR_MOVE, 0, data, resp);
			got = data[18:0];
		end
		check_resp(resp, RESP_OKAY, "first move read");
	endtask

	// the scan stalls on each move until it is read, so done comes only after draining
	task automatic drain_moves(input int p, input bit use_delay);
		logic [31:0] data;
		axi_resp_e   resp;
		move_t       got;
		int          idx;
		int          delay;
		int          reads;
		bit          finished;
		idx = 0;
		reads = 0;
		finished = 1'b0;
		while (!finished) begin
			reads++;
			if (reads > READ_LIMIT)
				report_failure("run never finished while its moves were read");
			delay = 0;
			if (use_delay) begin
				rng_state = xorshift32(rng_state);
				delay = rng_state % 6;
			end
			bus_read(ADDR_MOVE, delay, data, resp);
			check_resp(resp, RESP_OKAY, "move read");
			check_data({data[31:19], 19'd0}, 32'd0, "move read upper bits");
			got = data[18:0];
			if (got.flags.invalid) begin
				// nothing offered right now, between cells or at the end of the run
				check_move(got, none_word, "idle move word");
				bus_read(ADDR_STATUS, 0, data, resp);
				check_resp(resp, RESP_OKAY, "status read");
				if (data[1])
					finished = 1'b1;
				else
					check_status(data[0], data[1], 1'b1, 1'b0, "status while running");
			end else begin
				if (idx >= exp_count[p])
					report_mismatch($sformatf("position %0d gave an extra move %05h", p, got));
				check_move(got, exp_moves[exp_first[p] + idx],
					$sformatf("position %0d move %0d", p, idx));
				idx++;
			end
		end
		check_status(data[0], data[1], 1'b0, 1'b1, "status at end of run");
		if (idx != exp_count[p])
			report_mismatch($sformatf("position %0d gave %0d moves, expected %0d",
				p, idx, exp_count[p]));
		// nothing is left once the run is done
		bus_read(ADDR_MOVE, 0, data, resp);
		check_resp(resp, RESP_OKAY, "move read after end of run");
		check_move(data[18:0], none_word, "move read after end of run");
	endtask

	initial begin
		logic [31:0] data;
		axi_resp_e   resp;
		move_t       got;
		int          cnt;
		err_cnt = 0;
		rng_state = 32'hc441_09bf;
		none_word = '0;
		none_word.flags.invalid = 1'b1;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wvalid <= 1'b0;
		bready <= 1'b1;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		read_vectors();
		if (num_pos < 2)
			report_failure("vector file holds fewer than two positions");
		if (exp_count[0] == 0)
			report_failure("first position in the vector file has no moves");
		cnt = 0;
		while (arst_n !== 1'b1) begin
			cnt++;
			if (cnt > WAIT_LIMIT)
				report_failure("reset was never released");
			@(posedge clk);
			if (arst_n !== 1'b1)
				check_data({27'd0, awready, wready, bvalid, arready, rvalid}, 32'd0,
					"handshake outputs during reset");
		end

		// idle after reset
		bus_read(ADDR_STATUS, 0, data, resp);
		check_resp(resp, RESP_OKAY, "status read after reset");
		check_status(data[0], data[1], 1'b0, 1'b0, "status after reset");
		bus_read(ADDR_MOVE, 0, data, resp);
		check_resp(resp, RESP_OKAY, "move read after reset");
		check_move(data[18:0], none_word, "move read after reset");

		// every position, full speed then with random back-pressure
		for (int p = 0; p < num_pos; p++) begin
			load_board(p);
			start_run();
			drain_moves(p, 1'b0);
		end
		for (int p = 0; p < num_pos; p++) begin
			load_board(p);
			start_run();
			drain_moves(p, 1'b1);
		end

		// restart before the first list is drained
		load_board(0);
		start_run();
		read_first_move(got);
		check_move(got, exp_moves[exp_first[0]], "first move before restart");
		load_board(1);
		start_run();
		drain_moves(1, 1'b0);

		// unmapped addresses
		bus_write(12'h10c, 32'd1, resp);
		check_resp(resp, RESP_SLVERR, "write to unmapped address");
		bus_read(12'h200, 0, data, resp);
		check_resp(resp, RESP_SLVERR, "read of unmapped address");
		check_data(data, 32'd0, "read data of unmapped address");

		if (err_cnt == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("Test failed");
			$fatal(1, "errors were found");
		end
	end

endmodule

// ==== move_gen_top.f ====
+incdir+.
chess_pkg.sv
bus_pkg.sv
move_if.sv
board_loader.sv
square_cell.sv
move_grid.sv
move_collector.sv
move_gen_top.sv
tb_clock_gen.sv
tb_move_gen.sv

// ==== move_vectors.txt ====
# pos opens a block: 64 hex piece codes, one line per column, rows 0 to 7
# then the expected move words in hex in scan order, end closes the block
pos
0 1 0 0 0 0 0 2
0 0 a 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 c
0 0 0 0 0 0 1 0
0 0 0 0 0 0 0 0
9 0 0 0 0 0 0 0
6 1 0 0 0 0 0 0
10042 18043 1104a 001cd 001d6 3199f 309a7 01e30 00e31 10e7a 18e7b
end
pos
4 0 0 9 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0
0 d 0 0 0 0 0 0
0 0 0 0 0 0 0 b
0 0 0 0 0 0 c 0
0 0 0 0 0 6 0 5
00001 00002 01603 01003 00008 0060a 00010 00611 01621 01fef
00f74 00f75 01f76 01ff6 00ff7 00f7c 00f7e 00ffe
end
